// File: rtl/dma_pkg.sv
package dma_pkg;

	// Byte address on the AXI bus
	typedef logic [31:0] addr_t;

	// One 64-bit bus beat and its byte enables
	typedef logic [63:0] data_t;
	typedef logic [7:0] strb_t;

	// AXI response code
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// One write beat as stored in a burst buffer
	typedef struct packed {
		data_t data;
		strb_t strb;
	} wbeat_t;

	// Full burst waiting for the bus
	typedef struct packed {
		addr_t addr;
		logic valid;
	} burst_req_t;

	// Write master phases
	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA,
		RESP
	} writer_state_t;

endpackage

// File: rtl/burst_buffer.sv
`timescale 1ns/1ps

module burst_buffer #(
	parameter int BURST_LEN = 16
) (
	input logic clk,
	input logic rst,
	input logic beat_valid,
	input dma_pkg::wbeat_t beat,
	input dma_pkg::addr_t addr,
	input logic grant,
	input logic [$clog2(BURST_LEN)-1:0] rd_idx,
	input logic release_burst,
	output logic space,
	output dma_pkg::burst_req_t req,
	output dma_pkg::wbeat_t rd_beat
);
	import dma_pkg::*;

	localparam int IDX_W = $clog2(BURST_LEN);

	wbeat_t mem [BURST_LEN];
	logic [IDX_W-1:0] wr_cnt;
	addr_t start_addr;
	logic full;
	logic take;

	// Beats are only taken while the buffer is still filling
	assign take = beat_valid && !full;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_cnt <= '0;
			full <= 1'b0;
		end else begin
			if (take) begin
				// Counter wraps to zero after the last beat
				wr_cnt <= wr_cnt + 1'b1;
				if (wr_cnt == IDX_W'(BURST_LEN - 1)) begin
					full <= 1'b1;
				end
			end else if (release_burst && grant) begin
				full <= 1'b0;
			end
		end
	end

	// Beat storage
	always_ff @(posedge clk) begin
		if (take) begin
			mem[wr_cnt] <= beat;
		end
	end

	// Start address comes from the first beat only
	always_ff @(posedge clk) begin
		if (take && wr_cnt == '0) begin
			start_addr <= addr;
		end
	end

	assign space = !full;
	assign req = '{addr: start_addr, valid: full};

	// Writer reads the granted burst out by index
	assign rd_beat = mem[rd_idx];

endmodule

// File: rtl/burst_arbiter.sv
`timescale 1ns/1ps

module burst_arbiter (
	input logic clk,
	input logic rst,
	input dma_pkg::burst_req_t req0,
	input dma_pkg::burst_req_t req1,
	input dma_pkg::wbeat_t rd_beat0,
	input dma_pkg::wbeat_t rd_beat1,
	input logic burst_done,
	input logic burst_err,
	output logic grant0,
	output logic grant1,
	output logic start,
	output dma_pkg::burst_req_t sel_req,
	output dma_pkg::wbeat_t sel_beat,
	output logic sel,
	output logic done0,
	output logic done1,
	output logic err0,
	output logic err1
);
	import dma_pkg::*;

	logic busy;
	logic last;
	logic pick;
	logic any_req;

	// Round robin, the client after the last one served wins a tie
	assign any_req = req0.valid || req1.valid;
	assign pick = (req0.valid && req1.valid) ? !last : req1.valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			last <= 1'b1;
			sel <= 1'b0;
			start <= 1'b0;
			done0 <= 1'b0;
			done1 <= 1'b0;
			err0 <= 1'b0;
			err1 <= 1'b0;
		end else begin
			start <= 1'b0;
			done0 <= 1'b0;
			done1 <= 1'b0;
			err0 <= 1'b0;
			err1 <= 1'b0;
			if (!busy && any_req) begin
				busy <= 1'b1;
				sel <= pick;
				start <= 1'b1;
			end else if (busy && burst_done) begin
				// Grant drops here, result goes to the owner
				busy <= 1'b0;
				last <= sel;
				done0 <= !sel;
				done1 <= sel;
				err0 <= !sel && burst_err;
				err1 <= sel && burst_err;
			end
		end
	end

	assign grant0 = busy && !sel;
	assign grant1 = busy && sel;

	// Request and beat of the granted buffer
	assign sel_req = sel ? req1 : req0;
	assign sel_beat = sel ? rd_beat1 : rd_beat0;

endmodule

// File: rtl/axi_burst_writer.sv
`timescale 1ns/1ps

module axi_burst_writer #(
	parameter int BURST_LEN = 16
) (
	input logic clk,
	input logic rst,
	input logic start,
	input dma_pkg::burst_req_t sel_req,
	input dma_pkg::wbeat_t beat,
	output logic [$clog2(BURST_LEN)-1:0] beat_idx,
	output logic burst_done,
	output logic burst_err,

	// Write address channel
	output logic [3:0] m_axi_awid,
	output dma_pkg::addr_t m_axi_awaddr,
	output logic [7:0] m_axi_awlen,
	output logic [2:0] m_axi_awsize,
	output logic [1:0] m_axi_awburst,
	output logic m_axi_awlock,
	output logic [3:0] m_axi_awcache,
	output logic [2:0] m_axi_awprot,
	output logic [3:0] m_axi_awqos,
	output logic m_axi_awvalid,
	input logic m_axi_awready,

	// Write data channel
	output dma_pkg::data_t m_axi_wdata,
	output dma_pkg::strb_t m_axi_wstrb,
	output logic m_axi_wlast,
	output logic m_axi_wvalid,
	input logic m_axi_wready,

	// Write response channel
	input dma_pkg::axi_resp_t m_axi_bresp,
	input logic m_axi_bvalid,
	output logic m_axi_bready
);
	import dma_pkg::*;

	localparam int IDX_W = $clog2(BURST_LEN);
	localparam logic [1:0] BURST_INCR = 2'b01;

	if (BURST_LEN < 2 || BURST_LEN > 256 || (1 << IDX_W) != BURST_LEN) begin : g_len_check
		$error("BURST_LEN must be a power of two from 2 to 256");
	end

	writer_state_t state;
	logic [IDX_W-1:0] idx;
	addr_t aw_addr;
	logic launch;
	logic last_beat;

	assign launch = (state == IDLE) && start && sel_req.valid;
	assign last_beat = (idx == IDX_W'(BURST_LEN - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			idx <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (launch) begin
						state <= ADDR;
					end
				end
				ADDR: begin
					if (m_axi_awready) begin
						state <= DATA;
						idx <= '0;
					end
				end
				DATA: begin
					// One beat per W handshake
					if (m_axi_wready) begin
						idx <= idx + 1'b1;
						if (last_beat) begin
							state <= RESP;
						end
					end
				end
				RESP: begin
					if (m_axi_bvalid) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Burst start address, held through the address phase
	always_ff @(posedge clk) begin
		if (launch) begin
			aw_addr <= sel_req.addr;
		end
	end

	// Fixed AW fields, one full-width INCR burst
	assign m_axi_awid = '0;
	assign m_axi_awaddr = aw_addr;
	assign m_axi_awlen = 8'(BURST_LEN - 1);
	assign m_axi_awsize = 3'($clog2($bits(strb_t)));
	assign m_axi_awburst = BURST_INCR;
	assign m_axi_awlock = 1'b0;
	assign m_axi_awcache = 4'h2;
	assign m_axi_awprot = 3'b010;
	assign m_axi_awqos = '0;
	assign m_axi_awvalid = (state == ADDR);

	// Buffer memory is stable during the burst, so the beat holds under stall
	assign beat_idx = idx;
	assign m_axi_wdata = beat.data;
	assign m_axi_wstrb = beat.strb;
	assign m_axi_wvalid = (state == DATA);
	assign m_axi_wlast = (state == DATA) && last_beat;

	assign m_axi_bready = (state == RESP);

	// Anything but OKAY counts as a failed burst
	assign burst_done = (state == RESP) && m_axi_bvalid;
	assign burst_err = burst_done && (m_axi_bresp != RESP_OKAY);

endmodule

// File: rtl/dma_write_top.sv
`timescale 1ns/1ps

module dma_write_top #(
	parameter int BURST_LEN = 16
) (
	input logic clk,
	input logic rst,

	// Client 0
	input logic beat_valid0,
	input dma_pkg::wbeat_t beat0,
	input dma_pkg::addr_t addr0,
	output logic space0,
	output logic done0,
	output logic err0,

	// Client 1
	input logic beat_valid1,
	input dma_pkg::wbeat_t beat1,
	input dma_pkg::addr_t addr1,
	output logic space1,
	output logic done1,
	output logic err1,

	// AXI write master
	output logic [3:0] m_axi_awid,
	output dma_pkg::addr_t m_axi_awaddr,
	output logic [7:0] m_axi_awlen,
	output logic [2:0] m_axi_awsize,
	output logic [1:0] m_axi_awburst,
	output logic m_axi_awlock,
	output logic [3:0] m_axi_awcache,
	output logic [2:0] m_axi_awprot,
	output logic [3:0] m_axi_awqos,
	output logic m_axi_awvalid,
	input logic m_axi_awready,
	output dma_pkg::data_t m_axi_wdata,
	output dma_pkg::strb_t m_axi_wstrb,
	output logic m_axi_wlast,
	output logic m_axi_wvalid,
	input logic m_axi_wready,
	input dma_pkg::axi_resp_t m_axi_bresp,
	input logic m_axi_bvalid,
	output logic m_axi_bready
);
	import dma_pkg::*;

	burst_req_t req0;
	burst_req_t req1;
	burst_req_t sel_req;
	wbeat_t rd_beat0;
	wbeat_t rd_beat1;
	wbeat_t sel_beat;
	logic grant0;
	logic grant1;
	logic start;
	logic [$clog2(BURST_LEN)-1:0] beat_idx;
	logic burst_done;
	logic burst_err;

	burst_buffer #(
		.BURST_LEN(BURST_LEN)
	) i_buf0 (
		.clk(clk),
		.rst(rst),
		.beat_valid(beat_valid0),
		.beat(beat0),
		.addr(addr0),
		.grant(grant0),
		.rd_idx(beat_idx),
		.release_burst(burst_done),
		.space(space0),
		.req(req0),
		.rd_beat(rd_beat0)
	);

	burst_buffer #(
		.BURST_LEN(BURST_LEN)
	) i_buf1 (
		.clk(clk),
		.rst(rst),
		.beat_valid(beat_valid1),
		.beat(beat1),
		.addr(addr1),
		.grant(grant1),
		.rd_idx(beat_idx),
		.release_burst(burst_done),
		.space(space1),
		.req(req1),
		.rd_beat(rd_beat1)
	);

	// Select only feeds the beat and request muxes inside the arbiter
	burst_arbiter i_arb (
		.clk(clk),
		.rst(rst),
		.req0(req0),
		.req1(req1),
		.rd_beat0(rd_beat0),
		.rd_beat1(rd_beat1),
		.burst_done(burst_done),
		.burst_err(burst_err),
		.grant0(grant0),
		.grant1(grant1),
		.start(start),
		.sel_req(sel_req),
		.sel_beat(sel_beat),
		.sel(),
		.done0(done0),
		.done1(done1),
		.err0(err0),
		.err1(err1)
	);

	axi_burst_writer #(
		.BURST_LEN(BURST_LEN)
	) i_writer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.sel_req(sel_req),
		.beat(sel_beat),
		.beat_idx(beat_idx),
		.burst_done(burst_done),
		.burst_err(burst_err),
		.m_axi_awid(m_axi_awid),
		.m_axi_awaddr(m_axi_awaddr),
		.m_axi_awlen(m_axi_awlen),
		.m_axi_awsize(m_axi_awsize),
		.m_axi_awburst(m_axi_awburst),
		.m_axi_awlock(m_axi_awlock),
		.m_axi_awcache(m_axi_awcache),
		.m_axi_awprot(m_axi_awprot),
		.m_axi_awqos(m_axi_awqos),
		.m_axi_awvalid(m_axi_awvalid),
		.m_axi_awready(m_axi_awready),
		.m_axi_wdata(m_axi_wdata),
		.m_axi_wstrb(m_axi_wstrb),
		.m_axi_wlast(m_axi_wlast),
		.m_axi_wvalid(m_axi_wvalid),
		.m_axi_wready(m_axi_wready),
		.m_axi_bresp(m_axi_bresp),
		.m_axi_bvalid(m_axi_bvalid),
		.m_axi_bready(m_axi_bready)
	);

endmodule

// File: bench/dma_write_assert.sv
`timescale 1ns/1ps

module dma_write_assert (
	input logic clk,
	input logic rst,
	input dma_pkg::writer_state_t state,
	input logic awvalid,
	input logic awready,
	input dma_pkg::addr_t awaddr,
	input logic wvalid,
	input logic wready,
	input dma_pkg::data_t wdata,
	input dma_pkg::strb_t wstrb,
	input logic wlast,
	input logic bready
);
	import dma_pkg::*;

	int unsigned fail_count = 0;

	// AW request holds while the slave stalls
	a_aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid && $stable(awaddr))
	else begin
		fail_count++;
		$error("AWVALID or AWADDR changed before AWREADY");
	end

	// Same rule on the W channel
	a_w_hold: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast))
	else begin
		fail_count++;
		$error("W beat changed before WREADY");
	end

	a_wlast_valid: assert property (@(posedge clk) disable iff (rst) wlast |-> wvalid)
	else begin
		fail_count++;
		$error("WLAST high without WVALID");
	end

	a_bready_resp: assert property (@(posedge clk) disable iff (rst) bready |-> state == RESP)
	else begin
		fail_count++;
		$error("BREADY high outside the response phase");
	end

endmodule

bind axi_burst_writer dma_write_assert i_assert (
	.clk(clk),
	.rst(rst),
	.state(state),
	.awvalid(m_axi_awvalid),
	.awready(m_axi_awready),
	.awaddr(m_axi_awaddr),
	.wvalid(m_axi_wvalid),
	.wready(m_axi_wready),
	.wdata(m_axi_wdata),
	.wstrb(m_axi_wstrb),
	.wlast(m_axi_wlast),
	.bready(m_axi_bready)
);

// File: bench/tb_dma_write.sv
`timescale 1ns/1ps

module tb_dma_write;
	import dma_pkg::*;

	localparam int BURST_LEN = 16;
	localparam int N_BURSTS = 12;
	localparam int N_TIES = 4;
	localparam int TIMEOUT = 4000;

	logic clk;
	logic rst;
	logic [1:0] beat_valid;
	wbeat_t beat [2];
	addr_t addr [2];
	logic [1:0] space;
	logic [1:0] done;
	logic [1:0] err;

	logic [3:0] awid;
	addr_t awaddr;
	logic [7:0] awlen;
	logic [2:0] awsize;
	logic [1:0] awburst;
	logic awlock;
	logic [3:0] awcache;
	logic [2:0] awprot;
	logic [3:0] awqos;
	logic awvalid;
	logic awready;
	data_t wdata;
	strb_t wstrb;
	logic wlast;
	logic wvalid;
	logic wready;
	axi_resp_t bresp;
	logic bvalid;
	logic bready;

	integer seed;

	// Byte addressed memories, reference model and AXI slave
	logic [7:0] model_mem [addr_t];
	logic [7:0] slave_mem [addr_t];
	addr_t exp_addr [2][$];
	logic exp_err [2][$];
	int sent_cnt [2];

	// Monitor state
	int in_cnt [2];
	int done_cnt [2];
	logic [1:0] loaded;
	int w_cnt;
	logic owner;
	addr_t cur_addr;
	logic arb_idle;
	logic last_served;
	logic rr_known;
	logic exp_owner;
	logic owner_known;
	logic b_pending;
	logic b_taken;
	int b_delay;

	dma_write_top #(
		.BURST_LEN(BURST_LEN)
	) i_dma_write_top (
		.clk(clk),
		.rst(rst),
		.beat_valid0(beat_valid[0]),
		.beat0(beat[0]),
		.addr0(addr[0]),
		.space0(space[0]),
		.done0(done[0]),
		.err0(err[0]),
		.beat_valid1(beat_valid[1]),
		.beat1(beat[1]),
		.addr1(addr[1]),
		.space1(space[1]),
		.done1(done[1]),
		.err1(err[1]),
		.m_axi_awid(awid),
		.m_axi_awaddr(awaddr),
		.m_axi_awlen(awlen),
		.m_axi_awsize(awsize),
		.m_axi_awburst(awburst),
		.m_axi_awlock(awlock),
		.m_axi_awcache(awcache),
		.m_axi_awprot(awprot),
		.m_axi_awqos(awqos),
		.m_axi_awvalid(awvalid),
		.m_axi_awready(awready),
		.m_axi_wdata(wdata),
		.m_axi_wstrb(wstrb),
		.m_axi_wlast(wlast),
		.m_axi_wvalid(wvalid),
		.m_axi_wready(wready),
		.m_axi_bresp(bresp),
		.m_axi_bvalid(bvalid),
		.m_axi_bready(bready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s (got %0h, expected %0h)", $time, what, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout: %s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	endtask

	// One 4 KB aligned burst from client c with up to max_gap idle cycles before each beat
	task automatic send_burst(input int c, input int max_gap);
		addr_t base;
		data_t d;
		strb_t s;
		int b;
		int k;
		int gap;
		int wait_cnt;
		// Bit 24 tags the owning client and bit 20 makes the slave answer SLVERR
		base = ($random(seed) & 32'h00ff_f000) | (c << 24);
		exp_addr[c].push_back(base);
		exp_err[c].push_back(base[20]);
		sent_cnt[c]++;
		for (b = 0; b < BURST_LEN; b++) begin
			gap = $random(seed) & max_gap;
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			wait_cnt = 0;
			while (!space[c]) begin
				@(posedge clk);
				#1;
				wait_cnt++;
				if (wait_cnt > TIMEOUT) fail_timeout("client space stayed low");
			end
			d = {$random(seed), $random(seed)};
			s = $random(seed);
			beat_valid[c] = 1'b1;
			beat[c] = '{data: d, strb: s};
			addr[c] = base;
			for (k = 0; k < 8; k++) begin
				if (s[k]) model_mem[base + 32'(b * 8 + k)] = d[8*k +: 8];
			end
			@(posedge clk);
			#1;
			beat_valid[c] = 1'b0;
		end
	endtask

	task automatic run_client(input int c);
		int n;
		for (n = 0; n < N_BURSTS; n++) begin
			send_burst(c, 3);
		end
	endtask

	// Both buffers empty and no burst on the bus
	task automatic wait_idle();
		int wait_cnt;
		wait_cnt = 0;
		while (space !== 2'b11) begin
			@(posedge clk);
			#1;
			wait_cnt++;
			if (wait_cnt > TIMEOUT) fail_timeout("clients never became idle");
		end
	endtask

	// AXI slave and protocol monitor sampled at the clock edge
	always @(posedge clk) begin : slave_monitor
		int c;
		int k;
		if (!rst) begin
			for (c = 0; c < 2; c++) begin
				if (done[c]) begin
					check_equal(loaded[c], 1'b1, "done without a pending burst");
					check_equal(exp_err[c].size() > 0, 1'b1, "more dones than bursts");
					check_equal(err[c], exp_err[c].pop_front(), "err flag of burst");
					loaded[c] = 1'b0;
					done_cnt[c]++;
					last_served = 1'(c);
					rr_known = 1'b1;
					arb_idle = 1'b1;
				end else if (loaded[c]) begin
					check_equal(space[c], 1'b0, "space high while burst pending");
				end
			end
			// An idle arbiter takes a full buffer, on a tie the client after the last served
			if (arb_idle && (loaded[0] || loaded[1])) begin
				arb_idle = 1'b0;
				if (loaded[0] && loaded[1]) begin
					exp_owner = !last_served;
					owner_known = rr_known;
				end else begin
					exp_owner = loaded[1];
					owner_known = 1'b1;
				end
			end
			for (c = 0; c < 2; c++) begin
				if (beat_valid[c] && space[c]) begin
					in_cnt[c]++;
					if (in_cnt[c] == BURST_LEN) begin
						in_cnt[c] = 0;
						loaded[c] = 1'b1;
					end
				end
			end
			if (awvalid && awready) begin
				owner = awaddr[24];
				cur_addr = awaddr;
				w_cnt = 0;
				check_equal(exp_addr[owner].size() > 0, 1'b1, "AW without a queued burst");
				check_equal(awaddr, exp_addr[owner].pop_front(), "AWADDR");
				check_equal(awid, 4'h0, "AWID");
				check_equal(awlen, BURST_LEN - 1, "AWLEN");
				check_equal(awsize, 3'd3, "AWSIZE");
				check_equal(awburst, 2'b01, "AWBURST");
				check_equal(awlock, 1'b0, "AWLOCK");
				check_equal(awcache, 4'h2, "AWCACHE");
				check_equal(awprot, 3'd2, "AWPROT");
				check_equal(awqos, 4'h0, "AWQOS");
				if (owner_known) check_equal(owner, exp_owner, "round robin order");
			end
			if (wvalid && wready) begin
				w_cnt++;
				check_equal(wlast, w_cnt == BURST_LEN, "WLAST position");
				for (k = 0; k < 8; k++) begin
					if (wstrb[k]) slave_mem[cur_addr + 32'((w_cnt - 1) * 8 + k)] = wdata[8*k +: 8];
				end
				if (wlast) begin
					b_pending = 1'b1;
					b_delay = $random(seed) & 3;
				end
			end
			if (bvalid && bready) begin
				check_equal(w_cnt, BURST_LEN, "W beats in burst");
				b_taken = 1'b1;
			end
		end
		#1;
		awready = ($random(seed) & 3) != 0;
		wready = ($random(seed) & 3) != 0;
		if (b_taken) begin
			bvalid = 1'b0;
			b_taken = 1'b0;
		end else if (b_pending && !bvalid) begin
			if (b_delay == 0) begin
				bvalid = 1'b1;
				bresp = cur_addr[20] ? RESP_SLVERR : RESP_OKAY;
				b_pending = 1'b0;
			end else begin
				b_delay--;
			end
		end
	end

	initial begin
		int wait_cnt;
		int r;
		seed = 32'hcf1d_c30f;
		rst = 1'b1;
		beat_valid = '0;
		beat[0] = '0;
		beat[1] = '0;
		addr[0] = '0;
		addr[1] = '0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = RESP_OKAY;
		sent_cnt = '{0, 0};
		in_cnt = '{0, 0};
		done_cnt = '{0, 0};
		loaded = '0;
		w_cnt = 0;
		arb_idle = 1'b1;
		last_served = 1'b0;
		rr_known = 1'b0;
		exp_owner = 1'b0;
		owner_known = 1'b0;
		b_pending = 1'b0;
		b_taken = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		check_equal({awvalid, wvalid, wlast, bready, done}, '0, "outputs after reset");
		check_equal(space, 2'b11, "space after reset");

		fork
			run_client(0);
			run_client(1);
		join

		// Both clients fill in lockstep after a single burst from one of them
		for (r = 0; r < N_TIES; r++) begin
			wait_idle();
			send_burst(r % 2, 3);
			wait_idle();
			fork
				send_burst(0, 0);
				send_burst(1, 0);
			join
		end

		wait_cnt = 0;
		while (done_cnt[0] < sent_cnt[0] || done_cnt[1] < sent_cnt[1]) begin
			@(posedge clk);
			#1;
			wait_cnt++;
			if (wait_cnt > TIMEOUT) fail_timeout("last bursts never completed");
		end
		repeat (4) @(posedge clk);

		check_equal(done_cnt[0], sent_cnt[0], "dones for client 0");
		check_equal(done_cnt[1], sent_cnt[1], "dones for client 1");
		check_equal(exp_addr[0].size() + exp_addr[1].size(), 0, "bursts missing on AW");
		foreach (model_mem[a]) begin
			check_equal(slave_mem.exists(a), 1'b1, "byte missing in slave memory");
			check_equal(slave_mem[a], model_mem[a], "slave memory byte");
		end
		check_equal(slave_mem.num(), model_mem.num(), "bytes written to slave");
		check_equal(i_dma_write_top.i_writer.i_assert.fail_count, 0, "protocol assertions");

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: src.f
rtl/dma_pkg.sv
rtl/burst_buffer.sv
rtl/burst_arbiter.sv
rtl/axi_burst_writer.sv
rtl/dma_write_top.sv
bench/dma_write_assert.sv
bench/tb_dma_write.sv

// File: Bender.yml
package:
  name: dma_write

sources:
  - rtl/dma_pkg.sv
  - rtl/burst_buffer.sv
  - rtl/burst_arbiter.sv
  - rtl/axi_burst_writer.sv
  - rtl/dma_write_top.sv
  - target: simulation
    files:
      - bench/dma_write_assert.sv
      - bench/tb_dma_write.sv
